// File: Makefile
SIM       = verilator
TOP       = cpu6_mmu_tb
FILELIST  = cpu6_mmu.f
FLAGS     = --binary --timing --assert -j 0
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cpu6_mmu.f
source/cpu6_pkg.sv
source/micro_word_register.sv
source/data_path.sv
source/address_unit.sv
source/bus_interface.sv
source/cpu6_mmu.sv
tests/cpu6_mmu_tb.sv

// File: source/address_unit.sv
module address_unit
    import cpu6_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  strobe3_t   e6,
    input  strobe3_t   h11,
    input  strobe3_t   k11,
    input  byte_t      result_value,
    input  page_base_t page_base,

    output word_addr_t memory_address,
    output phys_addr_t address
);

    word_addr_t work_address;
    word_addr_t war_next;
    word_addr_t mar_next;
    byte_t      war_high_src;
    byte_t      war_low_src;
    byte_t      page_index;
    byte_t      page_entry;

    // Page table, one byte per page and base
    byte_t page_table [0:255];

    // A MAR copy in the same word redirects the byte loads to the MAR
    assign war_high_src = (e6 == e6_mar_from_war) ? memory_address[15:8] : result_value;
    assign war_low_src  = (e6 == e6_mar_from_war) ? memory_address[7:0] : result_value;

    always_comb begin
        war_next = work_address;
        case (h11)
            h11_war_inc:  war_next = work_address + 16'd1;
            h11_war_high: war_next[15:8] = war_high_src;
            default: ;
        endcase
        // Low byte load overrides the low half of an increment
        if (k11 == k11_war_low) begin
            war_next[7:0] = war_low_src;
        end
    end

    always_comb begin
        if (h11 == h11_mar_inc) begin
            mar_next = memory_address + 16'd1;  // Increment beats the copy
        end else if (e6 == e6_mar_from_war) begin
            mar_next = work_address;
        end else begin
            mar_next = memory_address;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            work_address   <= '0;
            memory_address <= '0;
        end else begin
            work_address   <= war_next;
            memory_address <= mar_next;
        end
    end

    // Top five address bits select the page within the base
    assign page_index = {memory_address[15:11], page_base};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                page_table[i] <= '0;
            end
        end else if (k11 == k11_page_write) begin
            page_table[page_index] <= result_value;
        end
    end

    assign page_entry = page_table[page_index];

    // Translated address, page frame above the 2K offset
    assign address = {page_entry, memory_address[10:0]};

endmodule

// File: source/bus_interface.sv
module bus_interface
    import cpu6_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  strobe2_t e7,
    input  strobe3_t k11,
    input  byte_t    data_in,
    input  byte_t    f_bus,

    output byte_t    bus_read_value,
    output byte_t    data_out,
    output logic     write_en
);

    logic write_delayed;  // Write requested in the previous cycle

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_read_value <= '0;
        end else if (e7 == e7_bus_read) begin
            bus_read_value <= data_in;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_out      <= '0;
            write_delayed <= 1'b0;
            write_en      <= 1'b0;
        end else begin
            write_en      <= write_delayed;  // One cycle behind the request
            write_delayed <= (k11 == k11_bus_write);
            if (k11 == k11_bus_write) begin
                data_out <= f_bus;
            end
        end
    end

endmodule

// File: source/cpu6_mmu.sv
module cpu6_mmu
    import cpu6_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  micro_word_t micro_in,
    input  byte_t       data_in,

    output phys_addr_t  address,
    output logic        write_en,
    output byte_t       data_out
);

    // Decoded microword fields
    dp_sel_t  dp_sel;
    strobe3_t e6;
    strobe3_t h11;
    strobe3_t k11;
    strobe2_t e7;
    byte_t    constant;
    logic     reg_low_select;

    // Internal buses and registers shared between blocks
    byte_t      f_bus;
    byte_t      result_value;
    page_base_t page_base;
    word_addr_t memory_address;
    byte_t      bus_read_value;

    micro_word_register u_micro_word_register (
        .clock          (clock),
        .reset          (reset),
        .micro_in       (micro_in),
        .dp_sel         (dp_sel),
        .e6             (e6),
        .h11            (h11),
        .k11            (k11),
        .e7             (e7),
        .constant       (constant),
        .reg_low_select (reg_low_select)
    );

    data_path u_data_path (
        .clock          (clock),
        .reset          (reset),
        .dp_sel         (dp_sel),
        .e6             (e6),
        .h11            (h11),
        .k11            (k11),
        .constant       (constant),
        .reg_low_select (reg_low_select),
        .memory_address (memory_address),
        .bus_read_value (bus_read_value),
        .f_bus          (f_bus),
        .result_value   (result_value),
        .page_base      (page_base)
    );

    address_unit u_address_unit (
        .clock          (clock),
        .reset          (reset),
        .e6             (e6),
        .h11            (h11),
        .k11            (k11),
        .result_value   (result_value),
        .page_base      (page_base),
        .memory_address (memory_address),
        .address        (address)
    );

    bus_interface u_bus_interface (
        .clock          (clock),
        .reset          (reset),
        .e7             (e7),
        .k11            (k11),
        .data_in        (data_in),
        .f_bus          (f_bus),
        .bus_read_value (bus_read_value),
        .data_out       (data_out),
        .write_en       (write_en)
    );

endmodule

// File: source/cpu6_pkg.sv
package cpu6_pkg;

    typedef logic [7:0]  byte_t;        // D bus, F bus, registers, bus data
    typedef logic [15:0] word_addr_t;   // Logical memory address
    typedef logic [18:0] phys_addr_t;   // Translated bus address
    typedef logic [55:0] micro_word_t;
    typedef logic [2:0]  page_base_t;
    typedef logic [3:0]  dp_sel_t;      // D-bus source code
    typedef logic [2:0]  strobe3_t;     // e6, h11 and k11 decoders
    typedef logic [1:0]  strobe2_t;     // e7 decoder

    // Reset word, a no-op in every field
    localparam micro_word_t micro_nop = '0;

    // Field positions in the microword
    localparam int d2d3_lsb           = 0;
    localparam int e6_lsb             = 4;
    localparam int k11_lsb            = 7;
    localparam int h11_lsb            = 10;
    localparam int e7_lsb             = 13;
    localparam int constant_lsb       = 16;  // Stored inverted
    localparam int reg_low_select_bit = 53;

    localparam strobe3_t e6_load_result    = 3'd1;
    localparam strobe3_t e6_load_index     = 3'd2;
    localparam strobe3_t e6_load_page_base = 3'd4;
    localparam strobe3_t e6_mar_from_war   = 3'd5;

    localparam strobe3_t h11_war_high = 3'd3;
    localparam strobe3_t h11_war_inc  = 3'd4;
    localparam strobe3_t h11_mar_inc  = 3'd5;
    localparam strobe3_t h11_swap     = 3'd7;

    localparam strobe3_t k11_reg_write  = 3'd4;
    localparam strobe3_t k11_page_write = 3'd5;
    localparam strobe3_t k11_war_low    = 3'd6;
    localparam strobe3_t k11_bus_write  = 3'd7;

    localparam strobe2_t e7_bus_read = 2'd3;

endpackage

// File: source/data_path.sv
module data_path
    import cpu6_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  dp_sel_t    dp_sel,
    input  strobe3_t   e6,
    input  strobe3_t   h11,
    input  strobe3_t   k11,
    input  byte_t      constant,
    input  logic       reg_low_select,
    input  word_addr_t memory_address,
    input  byte_t      bus_read_value,

    output byte_t      f_bus,
    output byte_t      result_value,
    output page_base_t page_base
);

    byte_t d_bus;
    byte_t swap_value;
    byte_t index_value;
    byte_t reg_addr;
    byte_t reg_read_value;

    // 256-byte register file
    byte_t reg_file [0:255];

    // Bit 0 goes through a NOR with the low select
    assign reg_addr = {index_value[7:1], ~(reg_low_select | index_value[0])};
    assign reg_read_value = reg_file[reg_addr];

    always_comb begin
        case (dp_sel)
            4'd0, 4'd4: d_bus = swap_value;
            4'd1, 4'd5: d_bus = reg_read_value;
            4'd2, 4'd6: d_bus = {~memory_address[15:12], memory_address[11:8]};  // High nibble inverted
            4'd3, 4'd7: d_bus = memory_address[7:0];
            4'd10:      d_bus = bus_read_value;   // Bus read latch
            4'd13:      d_bus = constant;         // Immediate from microword
            default:    d_bus = '0;
        endcase
    end

    // ALU is in pass-through mode
    assign f_bus = d_bus;

    // Registers loaded through the e6 decoder
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_value <= '0;
            index_value  <= '0;
            page_base    <= '0;
        end else begin
            case (e6)
                e6_load_result:    result_value <= f_bus;
                e6_load_index:     index_value  <= f_bus;
                e6_load_page_base: page_base    <= f_bus[$bits(page_base_t)-1:0];
                default: ;
            endcase
        end
    end

    // Swap register takes the D bus with nibbles exchanged
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            swap_value <= '0;
        end else if (h11 == h11_swap) begin
            swap_value <= {d_bus[3:0], d_bus[7:4]};
        end
    end

    // Register file write, read side is asynchronous
    always_ff @(posedge clock) begin
        if (k11 == k11_reg_write) begin
            reg_file[reg_addr] <= result_value;
        end
    end

endmodule

// File: source/micro_word_register.sv
module micro_word_register
    import cpu6_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  micro_word_t micro_in,

    output dp_sel_t     dp_sel,
    output strobe3_t    e6,
    output strobe3_t    h11,
    output strobe3_t    k11,
    output strobe2_t    e7,
    output byte_t       constant,
    output logic        reg_low_select
);

    // Microinstruction pipeline register
    micro_word_t pipeline_word;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pipeline_word <= micro_nop;
        end else begin
            pipeline_word <= micro_in;
        end
    end

    // D-bus source select
    assign dp_sel = pipeline_word[d2d3_lsb +: $bits(dp_sel_t)];

    // Decoder fields
    assign e6  = pipeline_word[e6_lsb +: $bits(strobe3_t)];
    assign h11 = pipeline_word[h11_lsb +: $bits(strobe3_t)];
    assign k11 = pipeline_word[k11_lsb +: $bits(strobe3_t)];
    assign e7  = pipeline_word[e7_lsb +: $bits(strobe2_t)];

    // Immediate data is held inverted in the microword
    assign constant = ~pipeline_word[constant_lsb +: $bits(byte_t)];

    // Forces register-file address bit 0 low together with index bit 0
    assign reg_low_select = pipeline_word[reg_low_select_bit];

endmodule

// File: tests/cpu6_mmu_tb.sv
module cpu6_mmu_tb
    import cpu6_pkg::*;
;

    logic        clock;
    logic        reset;
    micro_word_t micro_in;
    byte_t       data_in;
    phys_addr_t  address;
    logic        write_en;
    byte_t       data_out;

    // Vectors from the data file, one entry per clock
    micro_word_t micro_queue[$];
    byte_t       data_in_queue[$];
    phys_addr_t  address_queue[$];
    logic        write_en_queue[$];
    byte_t       data_out_queue[$];

    int     vector_count;
    longint watchdog_limit;
    bit     vectors_loaded;

    cpu6_mmu DUT (
        .clock    (clock),
        .reset    (reset),
        .micro_in (micro_in),
        .data_in  (data_in),
        .address  (address),
        .write_en (write_en),
        .data_out (data_out)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic report_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    // Reads every vector line, skipping comments and blank lines
    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        micro_word_t micro_value;
        byte_t       data_value;
        phys_addr_t  address_value;
        logic        write_value;
        byte_t       out_value;
        fd = $fopen("tests/cpu6_mmu_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test vector file tests/cpu6_mmu_tests.txt");
            report_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", micro_value, data_value,
                                     address_value, write_value, out_value);
                    if (fields != 5) begin
                        $display("Malformed line in the test vector file: %s", line);
                        report_failure();
                    end else begin
                        micro_queue.push_back(micro_value);
                        data_in_queue.push_back(data_value);
                        address_queue.push_back(address_value);
                        write_en_queue.push_back(write_value);
                        data_out_queue.push_back(out_value);
                    end
                end
            end
            $fclose(fd);
            if (micro_queue.size() == 0) begin
                $display("The test vector file holds no vectors");
                report_failure();
            end else begin
                vector_count   = micro_queue.size();
                watchdog_limit = longint'(vector_count + 20) * 100;  // Lines plus 20 cycles
                vectors_loaded = 1'b1;
            end
        end
    endtask

    task automatic check_outputs(input int line_no);
        assert (address === address_queue[line_no]) else begin
            $display("ERROR %0t: address is %05h, expected %05h at vector %0d",
                     $time, address, address_queue[line_no], line_no);
            report_failure();
        end
        assert (write_en === write_en_queue[line_no]) else begin
            $display("ERROR %0t: write_en is %0b, expected %0b at vector %0d",
                     $time, write_en, write_en_queue[line_no], line_no);
            report_failure();
        end
        assert (data_out === data_out_queue[line_no]) else begin
            $display("ERROR %0t: data_out is %02h, expected %02h at vector %0d",
                     $time, data_out, data_out_queue[line_no], line_no);
            report_failure();
        end
    endtask

    initial begin
        int index;
        reset    <= 1'b1;
        micro_in <= micro_nop;
        data_in  <= '0;
        load_vectors();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (index = 0; index < vector_count; index++) begin
            @(posedge clock);
            micro_in <= micro_queue[index];
            data_in  <= data_in_queue[index];
            @(negedge clock);  // Outputs settled since the rising edge
            check_outputs(index);
        end
        $display("Test passed");
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (vectors_loaded);
        #(watchdog_limit);
        $display("Timeout: the vectors did not finish within %0d time units", watchdog_limit);
        report_failure();
    end

endmodule

// File: tests/cpu6_mmu_tests.txt
# Columns: micro_in data_in | expected address write_en data_out (all hex)
# Expected values are sampled after the falling edge of the line's own cycle
00000000000000 00 00000 0 00
00000000A5039D 00 00000 0 00
00000000000000 00 00000 0 00
00000000000000 00 00000 0 5A
00000000000000 00 00000 1 5A
00000000000000 00 00000 0 5A
00000000FD004D 00 00000 0 5A
00000000C5001D 00 00000 0 5A
00000000000C00 00 00000 0 5A
0000000043001D 00 00000 0 5A
00000000000300 00 00000 0 5A
00000000000050 00 00000 0 5A
000000009A001D 00 00000 0 5A
00000000000280 00 002BC 0 5A
00000000FA004D 00 002BC 0 5A
000000003C001D 00 32ABC 0 5A
00000000000280 00 002BC 0 5A
00000000FD004D 00 002BC 0 5A
0000000000001D 00 61ABC 0 5A
00000000000300 00 32ABC 0 5A
00000000000050 00 32ABC 0 5A
00000000001400 00 32ABC 0 5A
00000000001450 00 32AFF 0 5A
00000000006000 00 32B00 0 5A
00000000000000 9C 32B01 0 5A
00000000001C0A 00 32B01 0 5A
00000000000380 00 32B01 0 5A
00000000000000 00 32B01 0 5A
00000000000000 00 32B01 0 C9
00000000000000 00 32B01 1 C9
00000000BF002D 00 32B01 0 C9
0000000058001D 00 32B01 0 C9
20000000000200 00 32B01 0 C9
00000000E7001D 00 32B01 0 C9
00000000000200 00 32B01 0 C9
00000000BE002D 00 32B01 0 C9
00000000000381 00 32B01 0 C9
00000000000000 00 32B01 0 C9
00000000000000 00 32B01 0 A7
00000000BF002D 00 32B01 1 A7
00000000000381 00 32B01 0 A7
00000000000000 00 32B01 0 A7
00000000000000 00 32B01 0 18
00000000000000 00 32B01 1 18
00000000000000 00 32B01 0 18
